//--- verilog/ti_mem_pkg.sv
// Address map and shared types for the TI-99/4A memory subsystem
// All addresses are 16-bit word addresses on the CPU side
// Loader addresses are byte addresses, even byte is the high lane

package ti_mem_pkg;

  // ====================
  // Widths
  // ====================
  localparam int C_ADR_BITS     = 23;  // CPU word address
  localparam int C_IDX_BITS     = 14;  // Widest region-local index
  localparam int C_LDR_ADR_BITS = 24;  // Loader byte address
  localparam int C_WORD_BITS    = 16;
  localparam int C_BYTE_BITS    = 8;

  // Index width per region
  localparam int C_ROM_BITS  = 12;  // 4K words
  localparam int C_DSR_BITS  = 12;  // 4K words
  localparam int C_PAD_BITS  = 9;   // 512 words
  localparam int C_GROM_BITS = 14;  // 16K words, system and extension each
  localparam int C_RAM_BITS  = 14;  // 32K bytes

  // RAM expansion stands in for SDRAM, so it gets wait states
  localparam int C_RAM_WAIT  = 6;
  localparam int C_WAIT_BITS = $clog2(C_RAM_WAIT + 1);

  // ====================
  // Word address map
  // ====================
  localparam logic [C_ADR_BITS-1:0] C_ROM_BASE  = 23'h000000;
  localparam logic [C_ADR_BITS-1:0] C_ROM_LAST  = 23'h000FFF;
  localparam logic [C_ADR_BITS-1:0] C_RAML_BASE = 23'h001000;  // RAM exp low 8K bytes
  localparam logic [C_ADR_BITS-1:0] C_RAML_LAST = 23'h001FFF;
  localparam logic [C_ADR_BITS-1:0] C_DSR_BASE  = 23'h002000;
  localparam logic [C_ADR_BITS-1:0] C_DSR_LAST  = 23'h002FFF;
  localparam logic [C_ADR_BITS-1:0] C_PAD_BASE  = 23'h004000;
  localparam logic [C_ADR_BITS-1:0] C_PAD_LAST  = 23'h0041FF;
  localparam logic [C_ADR_BITS-1:0] C_RAMH_BASE = 23'h005000;  // RAM exp high 24K bytes
  localparam logic [C_ADR_BITS-1:0] C_RAMH_LAST = 23'h007FFF;
  localparam logic [C_ADR_BITS-1:0] C_RAMH_OFS  = 23'h004000;  // High part sits above index 0x0FFF
  localparam logic [C_ADR_BITS-1:0] C_GROM_BASE = 23'h008000;
  localparam logic [C_ADR_BITS-1:0] C_GROM_LAST = 23'h00FFFF;

  // Bits 14:12 in this range pick the cartridge GROM store
  localparam logic [2:0] C_GEXT_SEL_LO = 3'd3;
  localparam logic [2:0] C_GEXT_SEL_HI = 3'd6;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_ROM,
    REG_DSR,
    REG_PAD,
    REG_GROM_SYS,
    REG_GROM_EXT,
    REG_RAM_EXP
  } region_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CPU_ACC,
    ST_CPU_WAIT,
    ST_LDR_ACC,
    ST_ACK
  } ctrl_state_e;

endpackage

//--- verilog/ti_addr_decode.sv
// Combinational word address decoder
// Anything outside the six regions decodes to REG_NONE with index 0
// RAM expansion low and high parts fold into one contiguous 16K store

`timescale 1ns/1ps

module ti_addr_decode
  import ti_mem_pkg::*;
(
  input  logic [C_ADR_BITS-1:0] i_adr,
  output region_e               o_region,
  output logic [C_IDX_BITS-1:0] o_index
);

  logic [C_ADR_BITS-1:0] ram_off;   // Address minus base of its RAM part
  logic                  in_rom;
  logic                  in_dsr;
  logic                  in_pad;
  logic                  in_raml;
  logic                  in_ramh;
  logic                  in_grom;
  logic                  grom_ext;

  // ====================
  // Range compares
  // ====================
  assign in_rom  = (i_adr >= C_ROM_BASE)  && (i_adr <= C_ROM_LAST);
  assign in_raml = (i_adr >= C_RAML_BASE) && (i_adr <= C_RAML_LAST);
  assign in_dsr  = (i_adr >= C_DSR_BASE)  && (i_adr <= C_DSR_LAST);
  assign in_pad  = (i_adr >= C_PAD_BASE)  && (i_adr <= C_PAD_LAST);
  assign in_ramh = (i_adr >= C_RAMH_BASE) && (i_adr <= C_RAMH_LAST);
  assign in_grom = (i_adr >= C_GROM_BASE) && (i_adr <= C_GROM_LAST);

  // GROM split on A14..A12, 3..6 is the cartridge extension
  assign grom_ext = (i_adr[14:12] >= C_GEXT_SEL_LO) && (i_adr[14:12] <= C_GEXT_SEL_HI);

  // 0x1000 -> index 0, 0x5000 -> index 0x1000
  assign ram_off = in_raml ? (i_adr - C_RAML_BASE) : (i_adr - C_RAMH_OFS);

  always_comb
  begin
    o_region = REG_NONE;
    o_index  = '0;
    if (in_rom)
    begin
      o_region = REG_ROM;
      o_index  = C_IDX_BITS'(i_adr[C_ROM_BITS-1:0]);
    end
    else if (in_dsr)
    begin
      o_region = REG_DSR;
      o_index  = C_IDX_BITS'(i_adr[C_DSR_BITS-1:0]);
    end
    else if (in_pad)
    begin
      o_region = REG_PAD;
      o_index  = C_IDX_BITS'(i_adr[C_PAD_BITS-1:0]);
    end
    else if (in_raml || in_ramh)
    begin
      o_region = REG_RAM_EXP;
      o_index  = C_IDX_BITS'(ram_off[C_RAM_BITS-1:0]);
    end
    else if (in_grom)
    begin
      // Both GROM stores index on bits 13:0
      o_region = grom_ext ? REG_GROM_EXT : REG_GROM_SYS;
      o_index  = C_IDX_BITS'(i_adr[C_GROM_BITS-1:0]);
    end
  end

endmodule

//--- verilog/ti_byte_ram.sv
// Single-clock word store built as two byte lanes
// Read is registered, one cycle after the address
// Read during write returns the old contents

`timescale 1ns/1ps

module ti_byte_ram
  import ti_mem_pkg::*;
#(
  parameter int ADDR_BITS = 12
)
(
  input  logic                   clk,
  input  logic                   i_we_hi,   // Writes bits 15:8
  input  logic                   i_we_lo,   // Writes bits 7:0
  input  logic [ADDR_BITS-1:0]   i_addr,
  input  logic [C_WORD_BITS-1:0] i_wdata,
  output logic [C_WORD_BITS-1:0] o_rdata
);

  logic [C_BYTE_BITS-1:0] mem_hi [2**ADDR_BITS];  // Even byte, TMS9900 big-endian
  logic [C_BYTE_BITS-1:0] mem_lo [2**ADDR_BITS];  // Odd byte

  always_ff @(posedge clk)
  begin
    if (i_we_hi)
      mem_hi[i_addr] <= i_wdata[C_WORD_BITS-1:C_BYTE_BITS];
    if (i_we_lo)
      mem_lo[i_addr] <= i_wdata[C_BYTE_BITS-1:0];
    o_rdata <= {mem_hi[i_addr], mem_lo[i_addr]};
  end

endmodule

//--- verilog/ti_mem_bank.sv
// The six on-chip region stores
// Lane strobes reach only the decoded store, REG_NONE swallows writes
// Read data follows the address by one cycle, unmapped reads give zero

`timescale 1ns/1ps

module ti_mem_bank
  import ti_mem_pkg::*;
(
  input  logic                   clk,
  input  region_e                i_region,
  input  logic [C_IDX_BITS-1:0]  i_index,
  input  logic                   i_wr_hi,
  input  logic                   i_wr_lo,
  input  logic [C_WORD_BITS-1:0] i_wdata,
  output logic [C_WORD_BITS-1:0] o_rdata
);

  region_e                region_q;  // Lines up with the registered RAM read
  logic [C_WORD_BITS-1:0] rom_rd;
  logic [C_WORD_BITS-1:0] dsr_rd;
  logic [C_WORD_BITS-1:0] pad_rd;
  logic [C_WORD_BITS-1:0] gsys_rd;
  logic [C_WORD_BITS-1:0] gext_rd;
  logic [C_WORD_BITS-1:0] ram_rd;

  // ====================
  // Stores
  // ====================
  ti_byte_ram #(.ADDR_BITS(C_ROM_BITS)) rom (
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_ROM)),
    .i_we_lo (i_wr_lo && (i_region == REG_ROM)),
    .i_addr  (i_index[C_ROM_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (rom_rd)
  );

  ti_byte_ram #(.ADDR_BITS(C_DSR_BITS)) dsr (
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_DSR)),
    .i_we_lo (i_wr_lo && (i_region == REG_DSR)),
    .i_addr  (i_index[C_DSR_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (dsr_rd)
  );

  ti_byte_ram #(.ADDR_BITS(C_PAD_BITS)) pad (  // Scratchpad
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_PAD)),
    .i_we_lo (i_wr_lo && (i_region == REG_PAD)),
    .i_addr  (i_index[C_PAD_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (pad_rd)
  );

  ti_byte_ram #(.ADDR_BITS(C_GROM_BITS)) grom_sys (
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_GROM_SYS)),
    .i_we_lo (i_wr_lo && (i_region == REG_GROM_SYS)),
    .i_addr  (i_index[C_GROM_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (gsys_rd)
  );

  ti_byte_ram #(.ADDR_BITS(C_GROM_BITS)) grom_ext (  // Cartridge GROM
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_GROM_EXT)),
    .i_we_lo (i_wr_lo && (i_region == REG_GROM_EXT)),
    .i_addr  (i_index[C_GROM_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (gext_rd)
  );

  ti_byte_ram #(.ADDR_BITS(C_RAM_BITS)) ram_exp (  // 32K expansion
    .clk     (clk),
    .i_we_hi (i_wr_hi && (i_region == REG_RAM_EXP)),
    .i_we_lo (i_wr_lo && (i_region == REG_RAM_EXP)),
    .i_addr  (i_index[C_RAM_BITS-1:0]),
    .i_wdata (i_wdata),
    .o_rdata (ram_rd)
  );

  always_ff @(posedge clk)
    region_q <= i_region;

  // Read mux
  always_comb
  begin
    case (region_q)
      REG_ROM:      o_rdata = rom_rd;
      REG_DSR:      o_rdata = dsr_rd;
      REG_PAD:      o_rdata = pad_rd;
      REG_GROM_SYS: o_rdata = gsys_rd;
      REG_GROM_EXT: o_rdata = gext_rd;
      REG_RAM_EXP:  o_rdata = ram_rd;
      default:      o_rdata = '0;  // Unmapped
    endcase
  end

endmodule

//--- verilog/ti_mem_ctrl.sv
// Memory cycle controller, CPU has priority over the loader
// CPU ack at k+2 after acceptance, RAM expansion adds C_RAM_WAIT cycles
// Busy covers every memory cycle, so a CPU pulse during busy is dropped
// Loader request must fall the cycle after its ack, one cycle is ignored
// CPU writes to ROM and system GROM are discarded, loader writes are not

`timescale 1ns/1ps

module ti_mem_ctrl
  import ti_mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_rst,
  // CPU side
  input  logic                      i_cpu_req,
  input  logic [C_ADR_BITS-1:0]     i_cpu_adr,
  input  logic                      i_cpu_we,
  input  logic                      i_cpu_ub_n,
  input  logic                      i_cpu_lb_n,
  input  logic [C_WORD_BITS-1:0]    i_cpu_wdata,
  output logic                      o_cpu_busy,
  output logic                      o_cpu_ack,
  output logic [C_WORD_BITS-1:0]    o_cpu_rdata,
  // Loader side
  input  logic                      i_ldr_rd_rq,
  input  logic                      i_ldr_wr_rq,
  input  logic [C_LDR_ADR_BITS-1:0] i_ldr_adr,
  input  logic [C_BYTE_BITS-1:0]    i_ldr_wdata,
  output logic                      o_ldr_rd_ack,
  output logic                      o_ldr_wr_ack,
  output logic [C_BYTE_BITS-1:0]    o_ldr_rdata,
  // Decoder and bank
  input  region_e                   i_region,
  input  logic [C_WORD_BITS-1:0]    i_rdata,
  output logic [C_ADR_BITS-1:0]     o_mem_adr,
  output logic                      o_wr_hi,
  output logic                      o_wr_lo,
  output logic [C_WORD_BITS-1:0]    o_wdata
);

  ctrl_state_e            state;
  logic [C_WAIT_BITS-1:0] wait_cnt;
  logic                   ldr_hold;     // Blocks the loader for one cycle after its ack

  // Latched request
  logic [C_ADR_BITS-1:0]  adr_q;
  logic                   we_q;
  logic                   hi_q;         // High lane selected
  logic                   lo_q;         // Low lane, also the loader read lane
  logic [C_WORD_BITS-1:0] wdata_q;
  logic [C_BYTE_BITS-1:0] ldr_rdata_q;

  logic                   cpu_go;
  logic                   ldr_go;
  logic                   ro_region;
  logic                   wr_phase;
  logic [C_BYTE_BITS-1:0] ldr_lane;

  // ====================
  // Arbitration
  // ====================
  assign cpu_go = i_cpu_req && !o_cpu_busy && (state == ST_IDLE);
  assign ldr_go = (i_ldr_rd_rq || i_ldr_wr_rq) && !i_cpu_req && !ldr_hold
                  && (state == ST_IDLE);

  always_ff @(posedge clk)
  begin
    if (i_rst)
    begin
      state        <= ST_IDLE;
      wait_cnt     <= '0;
      ldr_hold     <= 1'b0;
      o_cpu_busy   <= 1'b0;
      o_cpu_ack    <= 1'b0;
      o_ldr_rd_ack <= 1'b0;
      o_ldr_wr_ack <= 1'b0;
    end
    else
    begin
      ldr_hold <= o_ldr_rd_ack || o_ldr_wr_ack;  // Host drops its request here
      case (state)
        ST_IDLE:
        begin
          if (cpu_go)
          begin
            state      <= ST_CPU_ACC;
            o_cpu_busy <= 1'b1;
          end
          else if (ldr_go)
          begin
            state      <= ST_LDR_ACC;
            o_cpu_busy <= 1'b1;  // Keeps the CPU off while the loader runs
          end
        end
        ST_CPU_ACC:
        begin
          // Strobes are out this cycle, read data registers at this edge
          if ((i_region == REG_RAM_EXP) && (C_RAM_WAIT != 0))
          begin
            state    <= ST_CPU_WAIT;
            wait_cnt <= C_WAIT_BITS'(C_RAM_WAIT - 1);
          end
          else
          begin
            state     <= ST_ACK;
            o_cpu_ack <= 1'b1;
          end
        end
        ST_CPU_WAIT:
        begin
          if (wait_cnt == '0)
          begin
            state     <= ST_ACK;
            o_cpu_ack <= 1'b1;
          end
          else
            wait_cnt <= wait_cnt - 1'b1;
        end
        ST_LDR_ACC:
        begin
          state        <= ST_ACK;
          o_ldr_wr_ack <= we_q;
          o_ldr_rd_ack <= !we_q;
        end
        ST_ACK:  // One-cycle ack, busy drops after it
        begin
          state        <= ST_IDLE;
          o_cpu_busy   <= 1'b0;
          o_cpu_ack    <= 1'b0;
          o_ldr_rd_ack <= 1'b0;
          o_ldr_wr_ack <= 1'b0;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // ====================
  // Request capture
  // ====================
  always_ff @(posedge clk)
  begin
    if (cpu_go)
    begin
      adr_q   <= i_cpu_adr;
      we_q    <= i_cpu_we;
      hi_q    <= !i_cpu_ub_n;
      lo_q    <= !i_cpu_lb_n;
      wdata_q <= i_cpu_wdata;
    end
    else if (ldr_go)
    begin
      adr_q   <= i_ldr_adr[C_LDR_ADR_BITS-1:1];  // Byte to word address
      we_q    <= i_ldr_wr_rq;                    // Write wins if both are up
      hi_q    <= !i_ldr_adr[0];                  // Even byte is high lane
      lo_q    <= i_ldr_adr[0];
      wdata_q <= {i_ldr_wdata, i_ldr_wdata};     // Same byte on both lanes
    end
    if (o_ldr_rd_ack)
      ldr_rdata_q <= ldr_lane;
  end

  // Write only in the access cycle, ROM and system GROM are CPU read-only
  assign ro_region = (i_region == REG_ROM) || (i_region == REG_GROM_SYS);
  assign wr_phase  = we_q && (((state == ST_CPU_ACC) && !ro_region)
                              || (state == ST_LDR_ACC));
  assign o_wr_hi   = wr_phase && hi_q;
  assign o_wr_lo   = wr_phase && lo_q;
  assign o_wdata   = wdata_q;
  assign o_mem_adr = adr_q;

  // Read data path, valid in the ack cycle
  assign o_cpu_rdata = i_rdata;
  assign ldr_lane    = lo_q ? i_rdata[C_BYTE_BITS-1:0]
                            : i_rdata[C_WORD_BITS-1:C_BYTE_BITS];
  assign o_ldr_rdata = o_ldr_rd_ack ? ldr_lane : ldr_rdata_q;  // Held after the ack

endmodule

//--- verilog/ti_mem_top.sv
// Memory subsystem top, controller plus decoder plus region stores
// Single clock, synchronous active-high reset
// No init files, ROM and GROM are filled through the loader port

`timescale 1ns/1ps

module ti_mem_top
  import ti_mem_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_rst,
  // CPU side
  input  logic                      i_cpu_req,
  input  logic [C_ADR_BITS-1:0]     i_cpu_adr,
  input  logic                      i_cpu_we,
  input  logic                      i_cpu_ub_n,
  input  logic                      i_cpu_lb_n,
  input  logic [C_WORD_BITS-1:0]    i_cpu_wdata,
  output logic                      o_cpu_busy,
  output logic                      o_cpu_ack,
  output logic [C_WORD_BITS-1:0]    o_cpu_rdata,
  // Host loader
  input  logic                      i_ldr_rd_rq,
  input  logic                      i_ldr_wr_rq,
  input  logic [C_LDR_ADR_BITS-1:0] i_ldr_adr,
  input  logic [C_BYTE_BITS-1:0]    i_ldr_wdata,
  output logic                      o_ldr_rd_ack,
  output logic                      o_ldr_wr_ack,
  output logic [C_BYTE_BITS-1:0]    o_ldr_rdata
);

  logic [C_ADR_BITS-1:0]  mem_adr;
  region_e                region;
  logic [C_IDX_BITS-1:0]  index;
  logic                   wr_hi;
  logic                   wr_lo;
  logic [C_WORD_BITS-1:0] wdata;
  logic [C_WORD_BITS-1:0] rdata;

  ti_mem_ctrl u_ctrl (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_cpu_req    (i_cpu_req),
    .i_cpu_adr    (i_cpu_adr),
    .i_cpu_we     (i_cpu_we),
    .i_cpu_ub_n   (i_cpu_ub_n),
    .i_cpu_lb_n   (i_cpu_lb_n),
    .i_cpu_wdata  (i_cpu_wdata),
    .o_cpu_busy   (o_cpu_busy),
    .o_cpu_ack    (o_cpu_ack),
    .o_cpu_rdata  (o_cpu_rdata),
    .i_ldr_rd_rq  (i_ldr_rd_rq),
    .i_ldr_wr_rq  (i_ldr_wr_rq),
    .i_ldr_adr    (i_ldr_adr),
    .i_ldr_wdata  (i_ldr_wdata),
    .o_ldr_rd_ack (o_ldr_rd_ack),
    .o_ldr_wr_ack (o_ldr_wr_ack),
    .o_ldr_rdata  (o_ldr_rdata),
    .i_region     (region),
    .i_rdata      (rdata),
    .o_mem_adr    (mem_adr),
    .o_wr_hi      (wr_hi),
    .o_wr_lo      (wr_lo),
    .o_wdata      (wdata)
  );

  ti_addr_decode u_decode (
    .i_adr    (mem_adr),
    .o_region (region),
    .o_index  (index)
  );

  ti_mem_bank u_bank (
    .clk      (clk),
    .i_region (region),
    .i_index  (index),
    .i_wr_hi  (wr_hi),
    .i_wr_lo  (wr_lo),
    .i_wdata  (wdata),
    .o_rdata  (rdata)
  );

endmodule

//--- dv/ti_mem_assertions.sv
// Handshake and protection checks on the memory controller
// Bound into ti_mem_ctrl, needs a simulator with assertions enabled

`timescale 1ns/1ps

module ti_mem_assertions
  import ti_mem_pkg::*;
(
  input logic        clk,
  input logic        i_rst,
  input ctrl_state_e i_state,
  input region_e     i_region,
  input logic        i_cpu_busy,
  input logic        i_cpu_ack,
  input logic        i_ldr_rd_ack,
  input logic        i_ldr_wr_ack,
  input logic        i_wr_hi,
  input logic        i_wr_lo
);

  logic any_ack;
  logic ro_region;  // CPU read-only stores

  assign any_ack   = i_cpu_ack || i_ldr_rd_ack || i_ldr_wr_ack;
  assign ro_region = (i_region == REG_ROM) || (i_region == REG_GROM_SYS);

  ack_pulse: assert property (@(posedge clk) disable iff (i_rst) any_ack |=> !any_ack)
    else $error("ack longer than one cycle");

  // Sync reset, so outputs are clear one edge later
  reset_quiet: assert property (@(posedge clk)
    i_rst |=> !any_ack && !i_cpu_busy && !i_wr_hi && !i_wr_lo && (i_state == ST_IDLE))
    else $error("outputs not clear after reset");

  busy_hold: assert property (@(posedge clk) disable iff (i_rst)
    (i_cpu_busy && !any_ack) |=> i_cpu_busy)
    else $error("busy dropped before the ack");

  ack_in_busy: assert property (@(posedge clk) disable iff (i_rst) i_cpu_ack |-> i_cpu_busy)
    else $error("CPU ack outside busy");

  ro_protect: assert property (@(posedge clk) disable iff (i_rst)
    ((i_state == ST_CPU_ACC) && ro_region) |-> (!i_wr_hi && !i_wr_lo))
    else $error("lane strobe on a CPU write to ROM or system GROM");

endmodule

bind ti_mem_ctrl ti_mem_assertions u_assert (
  .clk          (clk),
  .i_rst        (i_rst),
  .i_state      (state),
  .i_region     (i_region),
  .i_cpu_busy   (o_cpu_busy),
  .i_cpu_ack    (o_cpu_ack),
  .i_ldr_rd_ack (o_ldr_rd_ack),
  .i_ldr_wr_ack (o_ldr_wr_ack),
  .i_wr_hi      (o_wr_hi),
  .i_wr_lo      (o_wr_lo)
);

//--- dv/ti_mem_tb.sv
// Table-driven testbench for the memory subsystem
// Loader fills every region first, CPU checks then run against that data
// Latency is counted in clocks from the request edge to the ack

`timescale 1ns/1ps

module ti_mem_tb
  import ti_mem_pkg::*;
();

  localparam int C_N_RAND = 24;              // Random RAM expansion writes
  localparam int C_OP_MAX = C_RAM_WAIT + 8;  // Worst-case clocks per operation
  localparam int C_LAT    = 2;               // Ack latency without wait states
  localparam int C_LAT_R  = 2 + C_RAM_WAIT;  // RAM expansion, CPU side only

  typedef enum logic [1:0] {OP_LRD, OP_LWR, OP_CRD, OP_CWR} op_e;

  typedef struct packed {
    op_e         op;
    logic [23:0] adr;   // Byte address for loader, word address for CPU
    logic        ub_n;
    logic        lb_n;
    logic [15:0] data;
    logic [15:0] expv;  // Read value, low byte for loader
    logic [7:0]  lat;   // Clocks from request to ack
  } entry_t;

  logic        clk;
  logic        i_rst;
  logic        i_cpu_req;
  logic [22:0] i_cpu_adr;
  logic        i_cpu_we;
  logic        i_cpu_ub_n;
  logic        i_cpu_lb_n;
  logic [15:0] i_cpu_wdata;
  logic        o_cpu_busy;
  logic        o_cpu_ack;
  logic [15:0] o_cpu_rdata;
  logic        i_ldr_rd_rq;
  logic        i_ldr_wr_rq;
  logic [23:0] i_ldr_adr;
  logic [7:0]  i_ldr_wdata;
  logic        o_ldr_rd_ack;
  logic        o_ldr_wr_ack;
  logic [7:0]  o_ldr_rdata;

  entry_t      tab[$];
  logic [15:0] sb [logic [22:0]];  // RAM expansion scoreboard by word address
  int          n_err = 0;
  int          n_chk = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;

  ti_mem_top UUT (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;  // 4 ns period

  // ====================
  // Run limit
  // ====================
  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("Timeout after %0d cycles, an ack never came", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic report_error(input string msg);
    n_err++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_val(input string name, input logic [15:0] expv, input logic [15:0] act);
    n_chk++;
    if (act !== expv)
    begin
      n_err++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, expv, act);
    end
  endtask

  function automatic entry_t make_entry(input op_e op, input logic [23:0] adr,
                                        input logic ub_n, input logic lb_n,
                                        input logic [15:0] data, input logic [15:0] expv,
                                        input int lat);
    entry_t e;
    e.op   = op;
    e.adr  = adr;
    e.ub_n = ub_n;
    e.lb_n = lb_n;
    e.data = data;
    e.expv = expv;
    e.lat  = 8'(lat);
    return e;
  endfunction

  function automatic void add_entry(input op_e op, input logic [23:0] adr, input logic ub_n,
                                    input logic lb_n, input logic [15:0] data,
                                    input logic [15:0] expv, input int lat);
    tab.push_back(make_entry(op, adr, ub_n, lb_n, data, expv, lat));
  endfunction

  // One request, wait for its ack, then one quiet cycle
  task automatic run_op(input entry_t e);
    int   clks;
    logic got_ack;
    logic is_cpu;
    is_cpu = (e.op == OP_CRD) || (e.op == OP_CWR);
    @(negedge clk);
    if (is_cpu)
    begin
      i_cpu_req   = 1'b1;
      i_cpu_adr   = e.adr[22:0];
      i_cpu_we    = (e.op == OP_CWR);
      i_cpu_ub_n  = e.ub_n;
      i_cpu_lb_n  = e.lb_n;
      i_cpu_wdata = e.data;
    end
    else
    begin
      i_ldr_adr   = e.adr;
      i_ldr_wdata = e.data[7:0];
      i_ldr_rd_rq = (e.op == OP_LRD);  // Held as a level until the ack
      i_ldr_wr_rq = (e.op == OP_LWR);
    end
    clks    = 0;
    got_ack = 1'b0;
    while (!got_ack && (clks < C_OP_MAX))
    begin
      @(negedge clk);
      clks++;
      i_cpu_req = 1'b0;  // CPU strobe is a single pulse
      case (e.op)
        OP_LRD:  got_ack = o_ldr_rd_ack;
        OP_LWR:  got_ack = o_ldr_wr_ack;
        default: got_ack = o_cpu_ack;
      endcase
      if (is_cpu && !o_cpu_busy)
        report_error($sformatf("busy low before the ack, address %h", e.adr));
    end
    if (!got_ack)
      report_error($sformatf("no ack for request at address %h", e.adr));
    else
      check_val("ack latency", 16'(e.lat), 16'(clks));
    if (got_ack && (e.op == OP_CRD))
      check_val("o_cpu_rdata", e.expv, o_cpu_rdata);
    if (got_ack && (e.op == OP_LRD))
      check_val("o_ldr_rdata", e.expv, {8'h00, o_ldr_rdata});
    @(negedge clk);
    i_ldr_rd_rq = 1'b0;  // Host drops its request after the ack
    i_ldr_wr_rq = 1'b0;
    if (o_cpu_busy || o_cpu_ack || o_ldr_rd_ack || o_ldr_wr_ack)
      report_error("busy or an ack still high the cycle after the ack");
    if (e.op == OP_LRD)
      check_val("o_ldr_rdata held", e.expv, {8'h00, o_ldr_rdata});
  endtask

  // Second CPU pulse during a RAM wait must be dropped
  task automatic check_back_pressure();
    int acks;
    @(negedge clk);
    i_cpu_req = 1'b1;
    i_cpu_adr = 23'h005000;
    i_cpu_we  = 1'b0;
    @(negedge clk);
    i_cpu_req = 1'b0;
    @(negedge clk);
    i_cpu_req = 1'b1;  // Busy by now
    i_cpu_adr = 23'h000010;
    @(negedge clk);
    i_cpu_req = 1'b0;
    acks      = 0;
    repeat (2 * C_OP_MAX)
    begin
      @(negedge clk);
      if (o_cpu_ack)
      begin
        acks++;
        check_val("o_cpu_rdata", 16'h4BFE, o_cpu_rdata);  // Word 0x5000, not 0x0010
      end
    end
    check_val("o_cpu_ack count", 16'd1, 16'(acks));
  endtask

  initial
  begin
    int unsigned r;
    logic [22:0] adr;
    logic [15:0] wd;
    void'($urandom(70202));  // Single seed for the run
    i_rst       = 1'b1;
    i_cpu_req   = 1'b0;
    i_cpu_adr   = '0;
    i_cpu_we    = 1'b0;
    i_cpu_ub_n  = 1'b1;
    i_cpu_lb_n  = 1'b1;
    i_cpu_wdata = '0;
    i_ldr_rd_rq = 1'b0;
    i_ldr_wr_rq = 1'b0;
    i_ldr_adr   = '0;
    i_ldr_wdata = '0;

    // ====================
    // Stimulus table
    // ====================
    add_entry(OP_LWR, 24'h000020, 1'b1, 1'b1, 16'h0012, 16'h0000, C_LAT);  // ROM 0x0010
    add_entry(OP_LWR, 24'h000021, 1'b1, 1'b1, 16'h0034, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h004020, 1'b1, 1'b1, 16'h0056, 16'h0000, C_LAT);  // DSR 0x2010
    add_entry(OP_LWR, 24'h004021, 1'b1, 1'b1, 16'h0078, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h00800A, 1'b1, 1'b1, 16'h009A, 16'h0000, C_LAT);  // PAD 0x4005
    add_entry(OP_LWR, 24'h00800B, 1'b1, 1'b1, 16'h00BC, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h01E000, 1'b1, 1'b1, 16'h00DE, 16'h0000, C_LAT);  // GROM sys 0xF000
    add_entry(OP_LWR, 24'h01E001, 1'b1, 1'b1, 16'h00AD, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h016000, 1'b1, 1'b1, 16'h00BE, 16'h0000, C_LAT);  // GROM ext 0xB000
    add_entry(OP_LWR, 24'h016001, 1'b1, 1'b1, 16'h00EF, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h00A000, 1'b1, 1'b1, 16'h00CA, 16'h0000, C_LAT);  // RAM 0x5000
    add_entry(OP_LWR, 24'h00A001, 1'b1, 1'b1, 16'h00FE, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h002000, 1'b1, 1'b1, 16'h0011, 16'h0000, C_LAT);  // RAM 0x1000, idx 0
    add_entry(OP_LWR, 24'h002001, 1'b1, 1'b1, 16'h0022, 16'h0000, C_LAT);
    add_entry(OP_LRD, 24'h000021, 1'b1, 1'b1, 16'h0000, 16'h0034, C_LAT);
    add_entry(OP_LRD, 24'h004020, 1'b1, 1'b1, 16'h0000, 16'h0056, C_LAT);
    add_entry(OP_LRD, 24'h01E000, 1'b1, 1'b1, 16'h0000, 16'h00DE, C_LAT);
    add_entry(OP_LRD, 24'h016001, 1'b1, 1'b1, 16'h0000, 16'h00EF, C_LAT);
    add_entry(OP_LRD, 24'h00A000, 1'b1, 1'b1, 16'h0000, 16'h00CA, C_LAT);
    add_entry(OP_LRD, 24'h00800B, 1'b1, 1'b1, 16'h0000, 16'h00BC, C_LAT);
    add_entry(OP_CRD, 24'h000010, 1'b0, 1'b0, 16'h0000, 16'h1234, C_LAT);  // Even byte on top
    add_entry(OP_CRD, 24'h002010, 1'b0, 1'b0, 16'h0000, 16'h5678, C_LAT);
    add_entry(OP_CRD, 24'h004005, 1'b0, 1'b0, 16'h0000, 16'h9ABC, C_LAT);
    add_entry(OP_CRD, 24'h00F000, 1'b0, 1'b0, 16'h0000, 16'hDEAD, C_LAT);
    add_entry(OP_CRD, 24'h00B000, 1'b0, 1'b0, 16'h0000, 16'hBEEF, C_LAT);
    add_entry(OP_CRD, 24'h005000, 1'b0, 1'b0, 16'h0000, 16'hCAFE, C_LAT_R);
    add_entry(OP_CRD, 24'h001000, 1'b0, 1'b0, 16'h0000, 16'h1122, C_LAT_R);  // Not 0x5000 data
    add_entry(OP_CWR, 24'h004005, 1'b0, 1'b1, 16'h5511, 16'h0000, C_LAT);  // High lane only
    add_entry(OP_CRD, 24'h004005, 1'b0, 1'b0, 16'h0000, 16'h55BC, C_LAT);
    add_entry(OP_CWR, 24'h004005, 1'b1, 1'b0, 16'h6677, 16'h0000, C_LAT);  // Low lane only
    add_entry(OP_CRD, 24'h004005, 1'b0, 1'b0, 16'h0000, 16'h5577, C_LAT);
    add_entry(OP_CWR, 24'h004005, 1'b0, 1'b0, 16'hA5C3, 16'h0000, C_LAT);
    add_entry(OP_CRD, 24'h004005, 1'b0, 1'b0, 16'h0000, 16'hA5C3, C_LAT);
    add_entry(OP_CWR, 24'h000010, 1'b0, 1'b0, 16'hFFFF, 16'h0000, C_LAT);  // ROM, dropped
    add_entry(OP_CRD, 24'h000010, 1'b0, 1'b0, 16'h0000, 16'h1234, C_LAT);
    add_entry(OP_CWR, 24'h00F000, 1'b0, 1'b0, 16'h0000, 16'h0000, C_LAT);  // GROM sys, dropped
    add_entry(OP_CRD, 24'h00F000, 1'b0, 1'b0, 16'h0000, 16'hDEAD, C_LAT);
    add_entry(OP_CWR, 24'h00B000, 1'b0, 1'b0, 16'h1357, 16'h0000, C_LAT);  // GROM ext is writable
    add_entry(OP_CRD, 24'h00B000, 1'b0, 1'b0, 16'h0000, 16'h1357, C_LAT);
    add_entry(OP_CRD, 24'h00F000, 1'b0, 1'b0, 16'h0000, 16'hDEAD, C_LAT);
    add_entry(OP_CWR, 24'h003000, 1'b0, 1'b0, 16'hFFFF, 16'h0000, C_LAT);  // Unmapped
    add_entry(OP_CRD, 24'h003000, 1'b0, 1'b0, 16'h0000, 16'h0000, C_LAT);
    add_entry(OP_LWR, 24'h006000, 1'b1, 1'b1, 16'h0077, 16'h0000, C_LAT);
    add_entry(OP_LRD, 24'h006000, 1'b1, 1'b1, 16'h0000, 16'h0000, C_LAT);
    add_entry(OP_CWR, 24'h005000, 1'b0, 1'b1, 16'h4B00, 16'h0000, C_LAT_R);
    add_entry(OP_CRD, 24'h005000, 1'b0, 1'b0, 16'h0000, 16'h4BFE, C_LAT_R);
    add_entry(OP_LRD, 24'h00A000, 1'b1, 1'b1, 16'h0000, 16'h004B, C_LAT);
    add_entry(OP_LRD, 24'h00A001, 1'b1, 1'b1, 16'h0000, 16'h00FE, C_LAT);

    cycle_limit = 5 + (tab.size() + 2 * C_N_RAND + 3) * C_OP_MAX + 100;

    repeat (5) @(negedge clk);
    i_rst = 1'b0;
    if ((o_cpu_busy !== 1'b0) || (o_cpu_ack !== 1'b0)
        || (o_ldr_rd_ack !== 1'b0) || (o_ldr_wr_ack !== 1'b0))
      report_error("busy or an ack high after reset");

    foreach (tab[i])
      run_op(tab[i]);
    check_back_pressure();

    // ====================
    // Random RAM expansion
    // ====================
    for (int i = 0; i < C_N_RAND; i++)
    begin
      r   = $urandom % 32'h4000;  // Store index, folded back to a word address
      adr = (r < 32'h1000) ? 23'(r + 32'h1000) : 23'(r + 32'h4000);
      wd  = 16'($urandom);
      sb[adr] = wd;
      run_op(make_entry(OP_CWR, {1'b0, adr}, 1'b0, 1'b0, wd, 16'h0000, C_LAT_R));
    end
    foreach (sb[a])
      run_op(make_entry(OP_CRD, {1'b0, a}, 1'b0, 1'b0, 16'h0000, sb[a], C_LAT_R));

    $display("Checks: %0d  Errors: %0d", n_chk, n_err);
    if (n_err == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

//--- ti_mem_top.f
verilog/ti_mem_pkg.sv
verilog/ti_addr_decode.sv
verilog/ti_byte_ram.sv
verilog/ti_mem_bank.sv
verilog/ti_mem_ctrl.sv
verilog/ti_mem_top.sv
dv/ti_mem_assertions.sv
dv/ti_mem_tb.sv

//--- Makefile
# Verilator build and run of the memory subsystem testbench
# Override any variable on the command line, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= ti_mem_tb
FILELIST  ?= ti_mem_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  := Result: PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
